// ==== logic/trdb_pkg.sv ====
// ====================================================================
// sizes, format codes and payload layout shared by the branch tracer
// every design file refers to these by scoped name
// ====================================================================

package trdb_pkg;

    // branch map capacity and the width of a branch count
    localparam int map_len = 31;
    localparam int count_w = 5;

    // sequence number carried by every packet
    localparam int seq_w = 5;

    // a partial packet gives up map bits to hold its count
    localparam int part_len = map_len - count_w;

    localparam logic [count_w-1:0] count_max = count_w'(map_len);
    localparam logic [count_w-1:0] part_max  = count_w'(part_len);

    // packet FIFO
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam logic [fifo_ptr_w:0] fifo_cnt_max = (fifo_ptr_w + 1)'(fifo_depth);

    // format bit, msb of every packet
    localparam logic fmt_full    = 1'b1;
    localparam logic fmt_partial = 1'b0;

    // format bit plus 36-bit payload
    localparam int pkt_w = 1 + seq_w + map_len;

    // payload below the format bit, read through the view that the
    // format bit selects
    typedef union packed {
        // full map, count is implicitly map_len
        struct packed {
            logic [seq_w-1:0]   seq;
            logic [map_len-1:0] map;
        } full;
        // closed early, explicit count and the low map bits only
        struct packed {
            logic [count_w-1:0]  branches;
            logic [seq_w-1:0]    seq;
            logic [part_len-1:0] map;
        } partial;
    } branch_payload_u;

endpackage

// ==== logic/trdb_branch_map.sv ====
// ====================================================================
// collects retired conditional branches, one bit each, 1 = not taken
// flush restarts the map, keeping a branch that retires alongside it
// ====================================================================

`timescale 1ns/10ps

module trdb_branch_map (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         valid_i,
    input  logic                         branch_taken_i,
    input  logic                         flush_i,
    output logic [trdb_pkg::map_len-1:0] map_o,
    output logic [trdb_pkg::count_w-1:0] branches_o,
    output logic                         is_full_o,
    output logic                         is_empty_o
);

    logic [trdb_pkg::map_len-1:0] map_q;
    logic [trdb_pkg::map_len-1:0] map_d;
    logic [trdb_pkg::count_w-1:0] count_q;
    logic [trdb_pkg::count_w-1:0] count_d;
    logic                         full;
    logic                         empty;

    assign full  = (count_q == trdb_pkg::count_max);
    assign empty = (count_q == '0);

    // next map state
    always_comb begin
        map_d   = map_q;
        count_d = count_q;

        if (flush_i) begin
            map_d   = '0;
            count_d = '0;
        end

        // the slot index is the count after any flush, so a branch
        // coinciding with a flush lands in bit 0 of the new map
        if (valid_i && (flush_i || !full)) begin
            map_d[count_d] = ~branch_taken_i;
            count_d        = count_d + 1'b1;
        end
    end

    // branch count
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // map bits above the count are don't care
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q <= '0;
        end else begin
            map_q <= map_d;
        end
    end

    assign map_o      = map_q;
    assign branches_o = count_q;
    assign is_full_o  = full;
    assign is_empty_o = empty;

    // the packer must flush a full map before a new branch is taken
    a_no_accept_when_full: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (valid_i && full) |-> flush_i
    );

    // a full map stays full only for the one cycle the packer needs
    a_full_closes: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        full |=> !full || $changed(map_q)
    );

endmodule

// ==== logic/trdb_branch_packer.sv ====
// ====================================================================
// closes the branch map into full or partial packets
// full maps go out unconditionally, flush requests close smaller maps
// ====================================================================

`timescale 1ns/10ps

module trdb_branch_packer (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         flush_req_i,
    input  logic [trdb_pkg::map_len-1:0] map_i,
    input  logic [trdb_pkg::count_w-1:0] branches_i,
    input  logic                         is_full_i,
    input  logic                         is_empty_i,
    output logic                         map_flush_o,
    output logic                         push_o,
    output logic [trdb_pkg::pkt_w-1:0]   packet_o
);

    logic                        fits_partial;
    logic                        close_full;
    logic                        close_partial;
    logic                        pending_q;
    logic [trdb_pkg::seq_w-1:0]  seq_q;
    logic                        fmt;
    trdb_pkg::branch_payload_u   payload;

    // a partial packet has room for at most part_len branches
    assign fits_partial = (branches_i <= trdb_pkg::part_max);

    // a full map wins over a flush request in the same cycle
    assign close_full    = is_full_i;
    assign close_partial = !is_full_i && !is_empty_i && flush_req_i && fits_partial;

    assign push_o = close_full || close_partial;

    // restart the map on the same edge the packet is pushed
    assign map_flush_o = is_full_i || (flush_req_i && !is_empty_i && fits_partial);

    // flush requests that cannot fit a partial packet wait for the
    // map to fill, the full packet then answers them
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (close_full) begin
            pending_q <= 1'b0;
        end else if (flush_req_i && !fits_partial) begin
            pending_q <= 1'b1;
        end
    end

    // counts every push, even one the FIFO later drops
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seq_q <= '0;
        end else if (push_o) begin
            seq_q <= seq_q + 1'b1;
        end
    end

    // format the packet from the current map state
    always_comb begin
        payload = '0;
        if (close_full) begin
            fmt              = trdb_pkg::fmt_full;
            payload.full.seq = seq_q;
            payload.full.map = map_i;
        end else begin
            fmt                      = trdb_pkg::fmt_partial;
            payload.partial.branches = branches_i;
            payload.partial.seq      = seq_q;
            payload.partial.map      = map_i[trdb_pkg::part_len-1:0];
        end
    end

    assign packet_o = {fmt, payload};

    a_push_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        push_o |-> !is_empty_i
    );

    // a held flush means the map is already past partial size and
    // nothing closes it before it fills
    a_pending_waits: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pending_q |-> !is_empty_i && !fits_partial && !close_partial
    );

endmodule

// ==== logic/trdb_packet_fifo.sv ====
// ====================================================================
// fall-through packet FIFO between the packer and the trace sink
// pop is a plain strobe, a push into a full FIFO is lost and flagged
// ====================================================================

`timescale 1ns/10ps

module trdb_packet_fifo (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       push_i,
    input  logic [trdb_pkg::pkt_w-1:0] data_i,
    input  logic                       pop_i,
    output logic                       valid_o,
    output logic [trdb_pkg::pkt_w-1:0] data_o,
    output logic                       overflow_o
);

    logic [trdb_pkg::pkt_w-1:0]      mem_q [trdb_pkg::fifo_depth];
    logic [trdb_pkg::fifo_ptr_w-1:0] wr_ptr_q;
    logic [trdb_pkg::fifo_ptr_w-1:0] rd_ptr_q;
    logic [trdb_pkg::fifo_ptr_w:0]   count_q;
    logic                            is_full;
    logic                            is_empty;
    logic                            do_push;
    logic                            do_pop;
    logic                            drop;
    logic                            overflow_q;

    assign is_full  = (count_q == trdb_pkg::fifo_cnt_max);
    assign is_empty = (count_q == '0);

    // pop on empty is ignored
    assign do_pop = pop_i && !is_empty;

    // a pop in the same cycle frees the slot for the incoming packet
    assign do_push = push_i && (!is_full || do_pop);
    assign drop    = push_i && is_full && !do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            overflow_q <= 1'b0;
        end else if (drop) begin
            overflow_q <= 1'b1;
        end
    end

    assign valid_o    = !is_empty;
    assign data_o     = mem_q[rd_ptr_q];
    assign overflow_o = overflow_q;

    a_count_in_depth: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        count_q <= trdb_pkg::fifo_cnt_max
    );

endmodule

// ==== logic/trdb_branch_tracer.sv ====
// ====================================================================
// branch trace top: map collects outcomes, packer closes it into
// packets, FIFO holds them until the trace sink pops
// ====================================================================

`timescale 1ns/10ps

module trdb_branch_tracer (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       branch_valid_i,
    input  logic                       branch_taken_i,
    input  logic                       flush_req_i,
    input  logic                       pkt_pop_i,
    output logic                       pkt_valid_o,
    output logic [trdb_pkg::pkt_w-1:0] pkt_data_o,
    output logic                       overflow_o
);

    // map state towards the packer
    logic [trdb_pkg::map_len-1:0] map;
    logic [trdb_pkg::count_w-1:0] branches;
    logic                         map_full;
    logic                         map_empty;

    // packer outputs
    logic                         map_flush;
    logic                         push;
    logic [trdb_pkg::pkt_w-1:0]   packet;

    trdb_branch_map u_branch_map (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .valid_i        (branch_valid_i),
        .branch_taken_i (branch_taken_i),
        .flush_i        (map_flush),
        .map_o          (map),
        .branches_o     (branches),
        .is_full_o      (map_full),
        .is_empty_o     (map_empty)
    );

    trdb_branch_packer u_branch_packer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .flush_req_i (flush_req_i),
        .map_i       (map),
        .branches_i  (branches),
        .is_full_i   (map_full),
        .is_empty_i  (map_empty),
        .map_flush_o (map_flush),
        .push_o      (push),
        .packet_o    (packet)
    );

    trdb_packet_fifo u_packet_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .data_i     (packet),
        .pop_i      (pkt_pop_i),
        .valid_o    (pkt_valid_o),
        .data_o     (pkt_data_o),
        .overflow_o (overflow_o)
    );

endmodule

// ==== verif/tb_trdb_ref_model.svh ====
// ====================================================================
// reference model of the branch tracer included in the testbench module
// tracks map, pending flush, sequence number and FIFO contents per cycle
// ====================================================================

    // largest count that still fits a partial packet
    localparam int part_limit = 26;

    logic [trdb_pkg::map_len-1:0] model_bits    = '0;
    int                           model_cnt     = 0;
    logic                         model_pending = 1'b0;
    logic [trdb_pkg::seq_w-1:0]   model_seq     = '0;
    logic                         exp_overflow  = 1'b0;
    logic [trdb_pkg::pkt_w-1:0]   exp_q[$];

    // behavior counters checked at the end of the run
    int n_full        = 0;
    int n_partial     = 0;
    int n_held        = 0;
    int n_empty_flush = 0;
    int n_coincident  = 0;
    int n_dropped     = 0;
    int n_gaps        = 0;

    // full packet is fmt 1, seq, 31 map bits
    // partial packet is fmt 0, count, seq, low 26 map bits
    function automatic logic [trdb_pkg::pkt_w-1:0] expected_packet(
        input logic        is_full,
        input logic [30:0] bits,
        input int          count,
        input logic [4:0]  seq
    );
        logic [4:0] cnt5;
        cnt5 = count[4:0];
        if (is_full) begin
            return {1'b1, seq, bits};
        end else begin
            return {1'b0, cnt5, seq, bits[25:0]};
        end
    endfunction

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // one clock edge of the design
    // the queue already reflects this edge's pop
    task automatic model_step(input logic valid, input logic taken, input logic flush_req);
        logic                       full;
        logic                       close;
        logic [trdb_pkg::pkt_w-1:0] pkt;
        full  = (model_cnt == trdb_pkg::map_len);
        close = 1'b0;
        pkt   = '0;
        if (full) begin
            pkt   = expected_packet(1'b1, model_bits, model_cnt, model_seq);
            close = 1'b1;
            // a held flush is answered by this full packet
            if (model_pending) begin
                n_held++;
            end
            model_pending = 1'b0;
            n_full++;
        end else if (flush_req && model_cnt == 0) begin
            n_empty_flush++;
        end else if (flush_req && model_cnt <= part_limit) begin
            pkt   = expected_packet(1'b0, model_bits, model_cnt, model_seq);
            close = 1'b1;
            n_partial++;
        end else if (flush_req) begin
            // too many branches for a partial packet, wait for the map to fill
            model_pending = 1'b1;
        end
        if (close) begin
            if (exp_q.size() == trdb_pkg::fifo_depth) begin
                exp_overflow = 1'b1;
                n_dropped++;
            end else begin
                exp_q.push_back(pkt);
            end
            model_seq++;
            if (valid) begin
                n_coincident++;
            end
            model_bits = '0;
            model_cnt  = 0;
        end
        if (valid && (close || !full)) begin
            model_bits[model_cnt] = ~taken;
            model_cnt++;
        end
    endtask

// ==== verif/tb_trdb_branch_tracer.sv ====
// ====================================================================
// testbench for the branch tracer: LFSR driven branches, flushes and pops
// every popped packet is compared against the included reference model
// ====================================================================

`timescale 1ns/10ps

module tb_trdb_branch_tracer;

    localparam int stim_len      = 4000;
    localparam int drain_len     = 200;
    localparam int reset_cycles  = 10;
    localparam int cycle_limit   = reset_cycles + stim_len + drain_len;
    localparam int dense_from    = 1000;
    localparam int withhold_from = 1500;

    logic                       clk;
    logic                       arst_n_i;
    logic                       branch_valid_i;
    logic                       branch_taken_i;
    logic                       flush_req_i;
    logic                       pkt_pop_i;
    logic                       pkt_valid_o;
    logic [trdb_pkg::pkt_w-1:0] pkt_data_o;
    logic                       overflow_o;

    logic [15:0] lfsr_q;
    int          stim_cycle;
    int          cycle_cnt;
    logic        valid_seen;
    logic        ovf_seen;
    int          last_seq;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_trdb_ref_model.svh"

    trdb_branch_tracer u_trdb_branch_tracer (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .branch_valid_i (branch_valid_i),
        .branch_taken_i (branch_taken_i),
        .flush_req_i    (flush_req_i),
        .pkt_pop_i      (pkt_pop_i),
        .pkt_valid_o    (pkt_valid_o),
        .pkt_data_o     (pkt_data_o),
        .overflow_o     (overflow_o)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b      = lfsr_q[0];
    endtask

    // packet sequence numbers as seen by the sink
    task automatic note_sequence(input logic [trdb_pkg::pkt_w-1:0] pkt);
        trdb_pkg::branch_payload_u payload;
        logic [4:0]                seq;
        payload = pkt[trdb_pkg::pkt_w-2:0];
        if (pkt[trdb_pkg::pkt_w-1] == trdb_pkg::fmt_full) begin
            seq = payload.full.seq;
        end else begin
            seq = payload.partial.seq;
        end
        if (last_seq >= 0 && seq != 5'(last_seq + 1)) begin
            n_gaps++;
        end
        last_seq = int'(seq);
    endtask

    task automatic finish_run();
        string missing;
        missing = "";
        if (n_full == 0) begin
            missing = "no full packet was produced during the run";
        end else if (n_partial == 0) begin
            missing = "no partial packet was produced during the run";
        end else if (n_empty_flush == 0) begin
            missing = "no flush request ever hit an empty map";
        end else if (n_held == 0) begin
            missing = "no flush request was held with 27 to 30 branches";
        end else if (n_coincident == 0) begin
            missing = "no branch ever coincided with a map close";
        end else if (n_dropped == 0 || n_gaps == 0) begin
            missing = "no packet was dropped on a full FIFO";
        end
        $display("full %0d partial %0d held %0d dropped %0d", n_full, n_partial, n_held,
                 n_dropped);
        if (missing == "") begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run(missing);
        end
    endtask

    initial begin
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        branch_valid_i = 1'b0;
        branch_taken_i = 1'b0;
        flush_req_i    = 1'b0;
        pkt_pop_i      = 1'b0;
        lfsr_q         = 16'd17;
        stim_cycle     = 0;
        cycle_cnt      = 0;
        valid_seen     = 1'b0;
        ovf_seen       = 1'b0;
        last_seq       = -1;
        repeat (reset_cycles) @(posedge clk);
        arst_n_i <= 1'b1;
    end

    always @(posedge clk) begin : drive_inputs
        logic v0, v1, tk, f0, f1, f2, f3, f4, pb;
        logic burst;
        logic withhold;
        logic valid_bit;
        logic flush_bit;
        if (arst_n_i) begin
            if (stim_cycle < stim_len) begin
                take_bit(v0);
                take_bit(v1);
                take_bit(tk);
                take_bit(f0);
                take_bit(f1);
                take_bit(f2);
                take_bit(f3);
                take_bit(f4);
                take_bit(pb);
                // two flushes in a row, the second one finds an empty map
                burst    = (stim_cycle % 256 == 128) || (stim_cycle % 256 == 129);
                // sink stalls until the FIFO has dropped a packet
                withhold = (stim_cycle >= withhold_from) && !ovf_seen;
                if (stim_cycle < dense_from) begin
                    valid_bit = v0;
                    flush_bit = f0 & f1 & f2 & f3;
                end else begin
                    valid_bit = v0 | v1;
                    flush_bit = f0 & f1 & f2 & f3 & f4;
                end
                branch_valid_i <= valid_bit && !burst;
                branch_taken_i <= tk;
                flush_req_i    <= flush_bit || burst;
                pkt_pop_i      <= valid_seen && !pkt_pop_i && pb && !withhold;
            end else begin
                branch_valid_i <= 1'b0;
                branch_taken_i <= 1'b0;
                flush_req_i    <= 1'b0;
                pkt_pop_i      <= valid_seen && !pkt_pop_i;
            end
            stim_cycle++;
        end
    end

    // outputs and inputs are stable at the falling edge
    always @(negedge clk) begin : check_outputs
        logic pop_eff;
        if (arst_n_i) begin
            valid_seen = pkt_valid_o;
            ovf_seen   = overflow_o;
            check_equal("pkt_valid_o", pkt_valid_o, exp_q.size() != 0);
            check_equal("overflow_o", overflow_o, exp_overflow);
            if (stim_cycle > stim_len + 1 && exp_q.size() == 0
                && model_cnt < trdb_pkg::map_len) begin
                finish_run();
            end else begin
                pop_eff = pkt_pop_i && (exp_q.size() != 0);
                if (pop_eff) begin
                    check_equal("pkt_data_o", pkt_data_o, exp_q[0]);
                    note_sequence(pkt_data_o);
                    void'(exp_q.pop_front());
                end
                model_step(branch_valid_i, branch_taken_i, flush_req_i);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            fail_run("run did not finish, FIFO not drained before the cycle limit");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+verif
logic/trdb_pkg.sv
logic/trdb_branch_map.sv
logic/trdb_branch_packer.sv
logic/trdb_packet_fifo.sv
logic/trdb_branch_tracer.sv
verif/tb_trdb_branch_tracer.sv
